// ==== source/decode_config.svh ====
// ====================
// Build-time settings for the decode front end
// Queue depth, sequence tag width, reserved register
// ====================

`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Entries in the micro-op FIFO between splitter and decoder
// Must be a power of two, two or more
`define DEC_QUEUE_DEPTH 4

// Width of the sequence tag carried by every micro-op
// Tags wrap at this width
`define DEC_SEQ_W 8

// Register number owned by machine mode
// User-mode code that names it takes a bad register fault
`define DEC_RSVD_REG 31

`endif

// ==== source/decode_pkg.sv ====
// ====================
// Shared types of the decode front end
// Vector typedefs, enums and the stream structs
// ====================

`default_nettype none

`include "decode_config.svh"

package decode_pkg;

	// Widths that carry a meaning
	typedef logic [31:0] instr_t;
	typedef logic [4:0] reg_num_t;
	typedef logic [31:0] imm_t;
	typedef logic [`DEC_SEQ_W-1:0] seq_t;

	// ====================
	// Encodings
	// ====================

	// Major opcode in bits 31 to 26 of an instruction
	typedef enum logic [5:0] {
		OP_NOP   = 6'd0,
		OP_ADD   = 6'd1,
		OP_SUB   = 6'd2,
		OP_AND   = 6'd3,
		OP_OR    = 6'd4,
		OP_MUL   = 6'd5,
		OP_ADDI  = 6'd8,
		OP_LOAD  = 6'd16,
		OP_STORE = 6'd17,
		OP_BEQ   = 6'd24,
		OP_FENCE = 6'd32
	} opcode_t;

	typedef enum logic {OM_USER, OM_MACHINE} op_mode_t;

	typedef enum logic [1:0] {FLT_NONE, FLT_BADREG, FLT_UNIMP} fault_t;

	// Splitter FSM: idle or emitting the high slot
	typedef enum logic {SPLIT_IDLE, SPLIT_HI} split_state_t;

	// ====================
	// Stream payloads
	// ====================

	// Bit 0 of slot_v qualifies lo, bit 1 qualifies hi
	typedef struct packed {
		instr_t lo;
		instr_t hi;
		logic [1:0] slot_v;
	} fetch_bundle_t;

	typedef struct packed {
		logic v;
		seq_t seq;
		instr_t ins;
	} micro_op_t;

	typedef struct packed {
		seq_t seq;
		logic nop;
		logic alu;
		logic mul;
		logic load;
		logic store;
		logic mem;
		logic branch;
		logic fence;
		logic sync;
		logic has_imm;
		logic has_rs2;
		imm_t imm;
		reg_num_t rs1;
		reg_num_t rs2;
		reg_num_t rd;
		logic rdz;
		fault_t cause;
	} decode_bus_t;

endpackage

`default_nettype wire

// ==== source/fetch_split.sv ====
// ====================
// Fetch bundle splitter
// Emits the low then the high slot as tagged micro-ops
// ====================

`default_nettype none

module fetch_split (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic bundle_valid,
	input  wire decode_pkg::fetch_bundle_t bundle,
	output logic bundle_ready,
	output logic uop_valid,
	output decode_pkg::micro_op_t uop,
	input  wire logic uop_ready
);

	decode_pkg::split_state_t state;
	decode_pkg::split_state_t state_nxt;
	logic valid_nxt;
	logic take_bundle;
	logic take_uop;
	decode_pkg::fetch_bundle_t held;
	decode_pkg::seq_t seq;

	assign take_bundle = bundle_valid && bundle_ready;
	assign take_uop = uop_valid && uop_ready;

	// ====================
	// FSM
	// ====================

	// In idle a pending micro-op is the low slot, in SPLIT_HI it is the high slot
	always_comb begin
		state_nxt = state;
		valid_nxt = uop_valid;
		case (state)
			decode_pkg::SPLIT_IDLE: begin
				if (take_bundle) begin
					valid_nxt = 1'b1;
				end else if (take_uop) begin
					state_nxt = decode_pkg::SPLIT_HI;
				end
			end
			decode_pkg::SPLIT_HI: begin
				if (take_uop) begin
					state_nxt = decode_pkg::SPLIT_IDLE;
					valid_nxt = 1'b0;
				end
			end
		endcase
	end

	// Ready is registered from the next state so it stays low during reset
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= decode_pkg::SPLIT_IDLE;
			uop_valid <= 1'b0;
			bundle_ready <= 1'b0;
			seq <= '0;
		end else begin
			state <= state_nxt;
			uop_valid <= valid_nxt;
			bundle_ready <= (state_nxt == decode_pkg::SPLIT_IDLE) && !valid_nxt;
			// One tag per micro-op handed over, wrapping naturally
			if (take_uop)
				seq <= seq + 1'b1;
		end
	end

	// The bundle is held until both of its slots have gone out
	always_ff @(posedge clk) begin
		if (take_bundle)
			held <= bundle;
	end

	// Slot select follows the state; the slot valid bit becomes the micro-op valid
	always_comb begin
		uop.seq = seq;
		if (state == decode_pkg::SPLIT_HI) begin
			uop.v = held.slot_v[1];
			uop.ins = held.hi;
		end else begin
			uop.v = held.slot_v[0];
			uop.ins = held.lo;
		end
	end

endmodule

`default_nettype wire

// ==== source/uop_queue.sv ====
// ====================
// Micro-op FIFO
// Circular buffer with valid/ready on both sides
// ====================

`default_nettype none

`include "decode_config.svh"

module uop_queue (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic in_valid,
	input  wire decode_pkg::micro_op_t in_uop,
	output logic in_ready,
	output logic out_valid,
	output decode_pkg::micro_op_t out_uop,
	input  wire logic out_ready
);

	localparam int DEPTH = `DEC_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam logic [PTR_W:0] FULL_CNT = DEPTH[PTR_W:0];

	decode_pkg::micro_op_t mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0] count;
	logic push;
	logic pop;

	// Full and empty come straight from the occupancy count
	assign in_ready = (count != FULL_CNT);
	assign out_valid = (count != '0);
	assign out_uop = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop leaves the count alone
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_uop;
	end

endmodule

`default_nettype wire

// ==== source/dec_opclass.sv ====
// ====================
// Opcode classifier
// Class flags, register usage and immediate
// ====================

`default_nettype none

module dec_opclass (
	input  wire decode_pkg::instr_t ins,
	output logic alu,
	output logic mul,
	output logic load,
	output logic store,
	output logic branch,
	output logic fence,
	output logic sync,
	output logic has_imm,
	output logic has_rs2,
	output logic has_rd,
	output logic uses_rs1,
	output logic unimp,
	output decode_pkg::imm_t imm
);

	decode_pkg::opcode_t opcode;
	decode_pkg::imm_t imm_sext;

	assign opcode = decode_pkg::opcode_t'(ins[31:26]);
	assign imm_sext = {{16{ins[15]}}, ins[15:0]};

	always_comb begin
		alu = 1'b0;
		mul = 1'b0;
		load = 1'b0;
		store = 1'b0;
		branch = 1'b0;
		fence = 1'b0;
		has_imm = 1'b0;
		has_rs2 = 1'b0;
		has_rd = 1'b0;
		uses_rs1 = 1'b0;
		unimp = 1'b0;
		case (opcode)
			// NOP decodes to nothing at all
			decode_pkg::OP_NOP: ;
			decode_pkg::OP_ADD, decode_pkg::OP_SUB, decode_pkg::OP_AND, decode_pkg::OP_OR: begin
				alu = 1'b1;
				{uses_rs1, has_rs2, has_rd} = 3'b111;
			end
			// Multiply is three-register like the ALU ops but goes to its own unit
			decode_pkg::OP_MUL: begin
				mul = 1'b1;
				{uses_rs1, has_rs2, has_rd} = 3'b111;
			end
			decode_pkg::OP_ADDI: begin
				alu = 1'b1;
				{uses_rs1, has_imm, has_rd} = 3'b111;
			end
			decode_pkg::OP_LOAD: begin
				load = 1'b1;
				{uses_rs1, has_imm, has_rd} = 3'b111;
			end
			// Store data comes from rs2, nothing is written back
			decode_pkg::OP_STORE: begin
				store = 1'b1;
				{uses_rs1, has_rs2, has_imm} = 3'b111;
			end
			// Compare rs1 with rs2, the immediate is the branch offset
			decode_pkg::OP_BEQ: begin
				branch = 1'b1;
				{uses_rs1, has_rs2, has_imm} = 3'b111;
			end
			decode_pkg::OP_FENCE: begin
				fence = 1'b1;
				has_imm = 1'b1;
			end
			default: unimp = 1'b1;
		endcase
	end

	// A fence with all low immediate bits set is a full sync
	assign sync = fence && (ins[7:0] == 8'hFF);
	assign imm = has_imm ? imm_sext : '0;

endmodule

`default_nettype wire

// ==== source/dec_regs.sv ====
// ====================
// Register field extractor
// Zero flags and reserved register check
// ====================

`default_nettype none

`include "decode_config.svh"

module dec_regs (
	input  wire decode_pkg::instr_t ins,
	input  wire decode_pkg::op_mode_t om,
	input  wire logic uses_rs1,
	input  wire logic has_rs2,
	input  wire logic has_rd,
	output decode_pkg::reg_num_t rs1,
	output decode_pkg::reg_num_t rs2,
	output decode_pkg::reg_num_t rd,
	output logic rdz,
	output logic badreg
);

	localparam decode_pkg::reg_num_t RSVD_REG = `DEC_RSVD_REG;

	decode_pkg::reg_num_t rd_f;
	decode_pkg::reg_num_t rs1_f;
	decode_pkg::reg_num_t rs2_f;

	// Raw fields, rs2 overlaps the top of the immediate
	assign rd_f = ins[25:21];
	assign rs1_f = ins[20:16];
	assign rs2_f = ins[15:11];

	// Unused fields read as register 0
	assign rs1 = uses_rs1 ? rs1_f : '0;
	assign rs2 = has_rs2 ? rs2_f : '0;
	assign rd = has_rd ? rd_f : '0;

	// Writing register 0 is the same as writing nothing
	assign rdz = !has_rd || (rd_f == '0);

	// Only fields the instruction really uses can trip the check
	assign badreg = (om == decode_pkg::OM_USER) &&
		((uses_rs1 && rs1_f == RSVD_REG) ||
		(has_rs2 && rs2_f == RSVD_REG) ||
		(has_rd && rd_f == RSVD_REG));

endmodule

`default_nettype wire

// ==== source/insn_decoder.sv ====
// ====================
// Registered decode stage
// Merges classifier and register results into the decode bus
// ====================

`default_nettype none

module insn_decoder (
	input  wire logic clk,
	input  wire logic rst,
	input  wire decode_pkg::op_mode_t om,
	input  wire logic in_valid,
	input  wire decode_pkg::micro_op_t in_uop,
	output logic in_ready,
	output logic out_valid,
	output decode_pkg::decode_bus_t dec,
	input  wire logic out_ready
);

	logic alu, mul, load, store, branch, fence, sync;
	logic has_imm, has_rs2, has_rd, uses_rs1, unimp, badreg, rdz;
	decode_pkg::imm_t imm;
	decode_pkg::reg_num_t rs1, rs2, rd;
	decode_pkg::decode_bus_t dec_nxt;
	logic take;

	dec_opclass u_opclass (
		.ins(in_uop.ins), .alu(alu), .mul(mul), .load(load), .store(store),
		.branch(branch), .fence(fence), .sync(sync), .has_imm(has_imm),
		.has_rs2(has_rs2), .has_rd(has_rd), .uses_rs1(uses_rs1), .unimp(unimp), .imm(imm)
	);

	dec_regs u_regs (
		.ins(in_uop.ins), .om(om), .uses_rs1(uses_rs1), .has_rs2(has_rs2), .has_rd(has_rd),
		.rs1(rs1), .rs2(rs2), .rd(rd), .rdz(rdz), .badreg(badreg)
	);

	// Accept when the output slot is empty or drains this cycle
	assign in_ready = !out_valid || out_ready;
	assign take = in_valid && in_ready;

	// ====================
	// Bus merge
	// ====================

	// An invalid slot is a bare nop carrying only its tag
	always_comb begin
		dec_nxt = '0;
		dec_nxt.seq = in_uop.seq;
		dec_nxt.nop = 1'b1;
		dec_nxt.rdz = 1'b1;
		dec_nxt.cause = decode_pkg::FLT_NONE;
		if (in_uop.v) begin
			dec_nxt.nop = (in_uop.ins[31:26] == decode_pkg::OP_NOP);
			dec_nxt.alu = alu;
			dec_nxt.mul = mul;
			dec_nxt.load = load;
			dec_nxt.store = store;
			dec_nxt.mem = load || store;
			dec_nxt.branch = branch;
			dec_nxt.fence = fence;
			dec_nxt.sync = sync;
			dec_nxt.has_imm = has_imm;
			dec_nxt.has_rs2 = has_rs2;
			dec_nxt.imm = imm;
			dec_nxt.rs1 = rs1;
			dec_nxt.rs2 = rs2;
			dec_nxt.rd = rd;
			dec_nxt.rdz = rdz;
			// Unimplemented wins over a bad register
			if (unimp)
				dec_nxt.cause = decode_pkg::FLT_UNIMP;
			else if (badreg)
				dec_nxt.cause = decode_pkg::FLT_BADREG;
		end
	end

	// Output register holds under back-pressure
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			dec <= '0;
			dec.nop <= 1'b1;
			dec.rdz <= 1'b1;
			dec.cause <= decode_pkg::FLT_NONE;
		end else if (take) begin
			out_valid <= 1'b1;
			dec <= dec_nxt;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== source/decode_top.sv ====
// ====================
// Decode front end top
// Splitter, micro-op FIFO and decoder in a chain
// ====================

`default_nettype none

module decode_top (
	input  wire logic clk,
	input  wire logic rst,
	input  wire decode_pkg::op_mode_t om,
	input  wire logic bundle_valid,
	input  wire decode_pkg::fetch_bundle_t bundle,
	output logic bundle_ready,
	output logic dec_valid,
	output decode_pkg::decode_bus_t dec,
	input  wire logic dec_ready
);

	// Splitter to FIFO
	logic split_valid;
	logic split_ready;
	decode_pkg::micro_op_t split_uop;

	// FIFO to decoder
	logic q_valid;
	logic q_ready;
	decode_pkg::micro_op_t q_uop;

	fetch_split u_fetch_split (
		.clk(clk), .rst(rst),
		.bundle_valid(bundle_valid), .bundle(bundle), .bundle_ready(bundle_ready),
		.uop_valid(split_valid), .uop(split_uop), .uop_ready(split_ready)
	);

	uop_queue u_uop_queue (
		.clk(clk), .rst(rst),
		.in_valid(split_valid), .in_uop(split_uop), .in_ready(split_ready),
		.out_valid(q_valid), .out_uop(q_uop), .out_ready(q_ready)
	);

	// Mode is sampled by the decode stage as each micro-op enters it
	insn_decoder u_insn_decoder (
		.clk(clk), .rst(rst), .om(om),
		.in_valid(q_valid), .in_uop(q_uop), .in_ready(q_ready),
		.out_valid(dec_valid), .dec(dec), .out_ready(dec_ready)
	);

endmodule

`default_nettype wire

// ==== verif/tb_decode_top.sv ====
// ====================
// Testbench for the decode front end
// Random bundles, reference decode, scoreboard and watchdog
// ====================

`default_nettype none

`include "decode_config.svh"

module tb_decode_top;

	localparam int NUM_BUNDLES = 200;
	localparam int TIMEOUT_CYCLES = NUM_BUNDLES * 2 * 8 + 200;
	// Bundles between two mode flips
	localparam int OM_PERIOD = 25;
	// Cycles allowed for the last slots to leave the pipeline
	localparam int DRAIN_CYCLES = 100;
	localparam logic [5:0] KNOWN_OPS [11] = '{
		6'd0, 6'd1, 6'd2, 6'd3, 6'd4, 6'd5, 6'd8, 6'd16, 6'd17, 6'd24, 6'd32
	};

	// One driven slot waiting for its decode result
	typedef struct packed {
		decode_pkg::instr_t ins;
		logic v;
		decode_pkg::op_mode_t om;
	} exp_entry_t;

	logic clk;
	logic rst;
	decode_pkg::op_mode_t om;
	logic bundle_valid;
	decode_pkg::fetch_bundle_t bundle;
	logic bundle_ready;
	logic dec_valid;
	decode_pkg::decode_bus_t dec;
	logic dec_ready;

	exp_entry_t exp_q[$];
	int errors;
	int outputs;

	decode_top u_decode_top (
		.clk(clk), .rst(rst), .om(om),
		.bundle_valid(bundle_valid), .bundle(bundle), .bundle_ready(bundle_ready),
		.dec_valid(dec_valid), .dec(dec), .dec_ready(dec_ready)
	);

	always #5 clk = ~clk;

	// ====================
	// Stimulus helpers
	// ====================

	function automatic logic is_known(input logic [5:0] op);
		logic found;
		found = 1'b0;
		for (int i = 0; i < 11; i++) begin
			if (KNOWN_OPS[i] == op)
				found = 1'b1;
		end
		return found;
	endfunction

	// Register 0 and the reserved register come up often on purpose
	function automatic decode_pkg::reg_num_t pick_reg();
		int sel;
		sel = int'($urandom_range(0, 3));
		if (sel == 0)
			return 5'd0;
		if (sel == 1)
			return 5'(`DEC_RSVD_REG);
		return 5'($urandom_range(0, 31));
	endfunction

	function automatic decode_pkg::instr_t make_slot();
		logic [5:0] op;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [15:0] low;
		int pick;
		pick = int'($urandom_range(0, 13));
		if (pick < 11) begin
			op = KNOWN_OPS[pick];
		end else begin
			op = 6'($urandom_range(0, 63));
			while (is_known(op))
				op = 6'($urandom_range(0, 63));
		end
		rd = pick_reg();
		rs1 = pick_reg();
		low = 16'($urandom_range(0, 65535));
		low[15:11] = pick_reg();
		// Half of the fences get the full sync pattern
		if (op == 6'd32 && $urandom_range(0, 1) == 1)
			low[7:0] = 8'hff;
		return {op, rd, rs1, low};
	endfunction

	// ====================
	// Reference model
	// ====================

	// Expected decode bus for one slot from the opcode table rules
	function automatic decode_pkg::decode_bus_t expected_decode(
		input decode_pkg::instr_t ins,
		input logic v,
		input decode_pkg::op_mode_t mode,
		input decode_pkg::seq_t tag
	);
		decode_pkg::decode_bus_t e;
		logic [5:0] op;
		logic r1;
		logic r2;
		logic wr;
		logic known;
		logic bad;
		logic [4:0] rsvd;
		e = '0;
		e.seq = tag;
		e.nop = 1'b1;
		e.rdz = 1'b1;
		e.cause = decode_pkg::FLT_NONE;
		if (!v)
			return e;
		op = ins[31:26];
		rsvd = 5'(`DEC_RSVD_REG);
		r1 = 1'b0;
		r2 = 1'b0;
		wr = 1'b0;
		known = 1'b1;
		e.nop = (op == 6'd0);
		case (op)
			6'd0: ;
			6'd1, 6'd2, 6'd3, 6'd4: begin
				e.alu = 1'b1;
				{r1, r2, wr} = 3'b111;
			end
			6'd5: begin
				e.mul = 1'b1;
				{r1, r2, wr} = 3'b111;
			end
			6'd8: begin
				e.alu = 1'b1;
				e.has_imm = 1'b1;
				{r1, wr} = 2'b11;
			end
			6'd16: begin
				e.load = 1'b1;
				e.has_imm = 1'b1;
				{r1, wr} = 2'b11;
			end
			6'd17: begin
				e.store = 1'b1;
				e.has_imm = 1'b1;
				{r1, r2} = 2'b11;
			end
			6'd24: begin
				e.branch = 1'b1;
				e.has_imm = 1'b1;
				{r1, r2} = 2'b11;
			end
			6'd32: begin
				e.fence = 1'b1;
				e.has_imm = 1'b1;
				e.sync = (ins[7:0] == 8'hff);
			end
			default: known = 1'b0;
		endcase
		e.mem = e.load || e.store;
		e.has_rs2 = r2;
		if (e.has_imm)
			e.imm = ins[15] ? {16'hffff, ins[15:0]} : {16'h0000, ins[15:0]};
		e.rs1 = r1 ? ins[20:16] : 5'd0;
		e.rs2 = r2 ? ins[15:11] : 5'd0;
		e.rd = wr ? ins[25:21] : 5'd0;
		e.rdz = !wr || (ins[25:21] == 5'd0);
		bad = (r1 && ins[20:16] == rsvd) || (r2 && ins[15:11] == rsvd) ||
			(wr && ins[25:21] == rsvd);
		// Unknown opcode outranks the register check
		if (!known)
			e.cause = decode_pkg::FLT_UNIMP;
		else if (bad && mode == decode_pkg::OM_USER)
			e.cause = decode_pkg::FLT_BADREG;
		return e;
	endfunction

	function automatic logic [10:0] flag_bits(input decode_pkg::decode_bus_t b);
		return {b.nop, b.alu, b.mul, b.load, b.store, b.mem, b.branch, b.fence,
			b.sync, b.has_imm, b.has_rs2};
	endfunction

	function automatic logic [15:0] reg_bits(input decode_pkg::decode_bus_t b);
		return {b.rs1, b.rs2, b.rd, b.rdz};
	endfunction

	task automatic check_field(input string what, input logic [31:0] got,
		input logic [31:0] want, input decode_pkg::seq_t tag, input decode_pkg::instr_t ins);
		assert (got == want) else begin
			errors++;
			$display("FAIL t=%0t tag %0d ins %h: %s is %h, expected %h",
				$time, tag, ins, what, got, want);
		end
	endtask

	// ====================
	// Scoreboard
	// ====================

	// Every accepted output is matched against the oldest outstanding slot
	initial begin : compare
		exp_entry_t head;
		decode_pkg::decode_bus_t want;
		decode_pkg::seq_t tag;
		errors = 0;
		outputs = 0;
		tag = '0;
		forever begin
			@(posedge clk);
			if (!rst && dec_valid && dec_ready) begin
				outputs++;
				assert (exp_q.size() != 0) else begin
					errors++;
					$display("Decode output at time %0t arrived with no slot outstanding",
						$time);
				end
				if (exp_q.size() != 0) begin
					head = exp_q.pop_front();
					want = expected_decode(head.ins, head.v, head.om, tag);
					check_field("tag", 32'(dec.seq), 32'(want.seq), tag, head.ins);
					check_field("flags", 32'(flag_bits(dec)), 32'(flag_bits(want)), tag,
						head.ins);
					check_field("imm", dec.imm, want.imm, tag, head.ins);
					check_field("regs", 32'(reg_bits(dec)), 32'(reg_bits(want)), tag,
						head.ins);
					check_field("cause", 32'(dec.cause), 32'(want.cause), tag, head.ins);
					tag++;
				end
			end
		end
	end

	// Downstream stalls roughly three cycles in ten
	initial begin : sink
		dec_ready = 1'b0;
		forever begin
			@(negedge clk);
			dec_ready = ($urandom_range(0, 9) >= 3);
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, %0d slots still waiting for a decode result",
			cycles, exp_q.size());
		$display("Errors: %0d checks, timeout reached", errors);
		$display("Simulation failed");
		$finish;
	end

	// ====================
	// Driver
	// ====================

	initial begin : drive
		int end_errors;
		logic accepted;
		decode_pkg::fetch_bundle_t b;
		void'($urandom(32'h20c0edbb));
		end_errors = 0;
		clk = 1'b0;
		rst = 1'b1;
		om = decode_pkg::OM_USER;
		bundle_valid = 1'b0;
		bundle = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		assert (!bundle_ready) else begin
			errors++;
			$display("FAIL t=%0t bundle_ready is high during reset", $time);
		end
		rst = 1'b0;
		for (int n = 0; n < NUM_BUNDLES; n++) begin
			// Mode only changes with nothing in flight
			if (n > 0 && n % OM_PERIOD == 0) begin
				while (exp_q.size() != 0)
					@(negedge clk);
				om = (om == decode_pkg::OM_USER) ? decode_pkg::OM_MACHINE : decode_pkg::OM_USER;
			end
			b.lo = make_slot();
			b.hi = make_slot();
			b.slot_v = 2'($urandom_range(0, 3));
			bundle = b;
			bundle_valid = 1'b1;
			accepted = 1'b0;
			while (!accepted) begin
				@(posedge clk);
				accepted = bundle_ready;
			end
			exp_q.push_back(exp_entry_t'{ins: b.lo, v: b.slot_v[0], om: om});
			exp_q.push_back(exp_entry_t'{ins: b.hi, v: b.slot_v[1], om: om});
			@(negedge clk);
			bundle_valid = 1'b0;
			// A bundle holds the splitter for at least two cycles
			assert (!bundle_ready) else begin
				errors++;
				$display("FAIL t=%0t bundle_ready still high after a bundle was taken",
					$time);
			end
			if ($urandom_range(0, 3) == 0)
				@(negedge clk);
		end
		for (int i = 0; i < DRAIN_CYCLES && exp_q.size() != 0; i++)
			@(negedge clk);
		// Extra cycles to catch a duplicated output
		repeat (20) @(negedge clk);
		assert (exp_q.size() == 0) else begin
			end_errors++;
			$display("Run ended with %0d driven slots never decoded", exp_q.size());
		end
		assert (outputs == 2 * NUM_BUNDLES) else begin
			end_errors++;
			$display("Saw %0d decode outputs for %0d driven slots", outputs, 2 * NUM_BUNDLES);
		end
		$display("Errors: %0d checks, %0d end of run", errors, end_errors);
		if (errors == 0 && end_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+source
source/decode_pkg.sv
source/fetch_split.sv
source/uop_queue.sv
source/dec_opclass.sv
source/dec_regs.sv
source/insn_decoder.sv
source/decode_top.sv
verif/tb_decode_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the decode front end testbench with Verilator and run it.
# The run passes only if the pass line shows up in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_decode_top -o tb_decode_top
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_decode_top)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation executable returned status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1
